// ==== design/rob_pkg.sv ====
// shared types for the reorder buffer back end
// imported by every design unit that needs tag, register or entry types
package rob_pkg;

    // widest dispatch or retire group the types are sized for
    localparam int MAX_N = 4;

    // architectural register file size, also the size of the map table
    localparam int NUM_ARCH_REGS = 32;

    // physical register tag; 0..31 are the initial mappings
    typedef logic [5:0] tag_t;

    // architectural register number
    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;

    // valid lanes in a group, 0 to MAX_N
    typedef logic [$clog2(MAX_N+1)-1:0] lane_count_t;

    // one ROB slot
    // complete is set by a tag broadcast and gates in-order release
    typedef struct packed {
        arch_reg_t dest;
        tag_t      tag;
        logic      complete;
    } rob_entry_t;

endpackage

// ==== design/dispatch_if.sv ====
// dispatch group from the input register into the ROB
// no ready here, space was already reserved by the input side
`timescale 1ns/1ps

interface dispatch_if #(
    parameter int N = 2
);
    import rob_pkg::*;

    // high for exactly one cycle per accepted group
    logic        valid;
    lane_count_t count;
    // lane 0 is the oldest instruction
    rob_entry_t  entries [N];

    modport source (
        output valid,
        output count,
        output entries
    );

    modport sink (
        input valid,
        input count,
        input entries
    );

endinterface

// ==== design/retire_if.sv ====
// retired group from the ROB head into the output register
// valid/ready handshake, the ROB head moves only on a transfer
`timescale 1ns/1ps

interface retire_if #(
    parameter int N = 2
);
    import rob_pkg::*;

    logic        valid;
    lane_count_t count;
    // lane 0 is the entry at the head
    rob_entry_t  entries [N];
    // from the output side, independent of valid
    logic        ready;

    modport source (
        output valid,
        output count,
        output entries,
        input  ready
    );

    modport sink (
        input  valid,
        input  count,
        input  entries,
        output ready
    );

endinterface

// ==== design/dispatch_stage.sv ====
// input side of the ROB; accepts whole groups only when they fit
// the accepted group is registered and handed to the ROB one cycle later
`timescale 1ns/1ps

module dispatch_stage #(
    parameter int N     = 2,
    parameter int DEPTH = 16
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         in_valid,
    input  rob_pkg::lane_count_t         in_count,
    input  rob_pkg::arch_reg_t           in_dest [N],
    input  rob_pkg::tag_t                in_tag [N],
    output logic                         in_ready,
    input  logic [$clog2(DEPTH+1)-1:0]   free_entries,
    dispatch_if.source                   disp
);

    localparam int CW = $clog2(DEPTH+1);

    // entry count wide enough for 0..DEPTH
    typedef logic [CW-1:0] occ_t;

    occ_t pending;
    occ_t avail;

    // the group sitting in the register is written this edge
    // so its slots are not free for a new group yet
    assign pending = disp.valid ? occ_t'(disp.count) : '0;
    assign avail = free_entries - pending;

    // all or nothing, the whole group must fit
    assign in_ready = avail >= occ_t'(in_count);

    // valid is a one-cycle pulse per accepted group
    always_ff @(posedge clock) begin
        if (reset) begin
            disp.valid <= 1'b0;
        end else begin
            disp.valid <= in_valid && in_ready;
        end
    end

    // payload, loaded only on a transfer
    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            disp.count <= in_count;
            for (int i = 0; i < N; i++) begin
                disp.entries[i].dest     <= in_dest[i];
                disp.entries[i].tag      <= in_tag[i];
                // every new instruction starts incomplete
                disp.entries[i].complete <= 1'b0;
            end
        end
    end

endmodule

// ==== design/reorder_buffer.sv ====
// circular reorder buffer, N-wide write at the tail and N-wide release at the head
// entries complete on a tag broadcast and leave strictly in program order
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int N     = 2,
    parameter int DEPTH = 16
) (
    input  logic                         clock,
    input  logic                         reset,
    dispatch_if.sink                     disp,
    input  logic                         done_valid [N],
    input  rob_pkg::tag_t                done_tag [N],
    output logic [$clog2(DEPTH+1)-1:0]   free_entries,
    retire_if.source                     ret
);

    import rob_pkg::*;

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH+1);

    // slot index, wraps for free since DEPTH is a power of two
    typedef logic [PW-1:0] ptr_t;
    // occupancy 0..DEPTH
    typedef logic [CW-1:0] occ_t;

    rob_entry_t entries_q [DEPTH];

    ptr_t head;
    ptr_t tail;
    // separate counter so head == tail is not ambiguous
    occ_t occupancy;

    logic [DEPTH-1:0] resident;
    lane_count_t      ret_cnt;
    occ_t             release_cnt;
    occ_t             write_cnt;

    // slot is live when its distance from the head is below occupancy
    always_comb begin
        ptr_t offset;
        for (int s = 0; s < DEPTH; s++) begin
            offset = ptr_t'(s) - head;
            resident[s] = occ_t'(offset) < occupancy;
        end
    end

    // release: contiguous completed run from the head, at most N
    always_comb begin
        ptr_t idx;
        logic stop;
        stop = 1'b0;
        ret_cnt = '0;
        for (int i = 0; i < N; i++) begin
            idx = head + ptr_t'(i);
            ret.entries[i] = entries_q[idx];
            // an incomplete entry blocks everything younger
            if (!stop && occ_t'(i) < occupancy && entries_q[idx].complete) begin
                ret_cnt = ret_cnt + lane_count_t'(1);
            end else begin
                stop = 1'b1;
            end
        end
    end

    assign ret.valid = ret_cnt != '0;
    assign ret.count = ret_cnt;

    // head only moves when the output side takes the group
    assign release_cnt = ret.ready ? occ_t'(ret_cnt) : '0;
    assign write_cnt = disp.valid ? occ_t'(disp.count) : '0;

    // space as seen after this cycle's release
    assign free_entries = occ_t'(DEPTH) - occupancy + release_cnt;

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            head      <= head + ptr_t'(release_cnt);
            tail      <= tail + ptr_t'(write_cnt);
            occupancy <= occupancy + write_cnt - release_cnt;
        end
    end

    // entry storage
    always_ff @(posedge clock) begin
        // tag match on any completion lane marks the live entry done
        for (int s = 0; s < DEPTH; s++) begin
            for (int k = 0; k < N; k++) begin
                if (done_valid[k] && resident[s] && entries_q[s].tag == done_tag[k]) begin
                    entries_q[s].complete <= 1'b1;
                end
            end
        end
        // new group lands at the tail, lane 0 first
        // a fresh write overrides any stale completion on a reused slot
        for (int j = 0; j < N; j++) begin
            if (disp.valid && j < int'(disp.count)) begin
                entries_q[tail + ptr_t'(j)] <= disp.entries[j];
            end
        end
    end

endmodule

// ==== design/retire_stage.sv ====
// output side; one-deep register for the retired group plus the architectural map
// each retiring lane reports the tag its dest mapped to before it, for the free list
`timescale 1ns/1ps

module retire_stage #(
    parameter int N = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    retire_if.sink                 ret,
    output logic                   ret_valid,
    input  logic                   ret_ready,
    output rob_pkg::lane_count_t   ret_count,
    output rob_pkg::arch_reg_t     ret_dest [N],
    output rob_pkg::tag_t          ret_tag [N],
    output rob_pkg::tag_t          ret_freed_tag [N]
);

    import rob_pkg::*;

    // committed mapping, arch reg to physical tag
    tag_t map_q [NUM_ARCH_REGS];
    tag_t map_next [NUM_ARCH_REGS];
    tag_t freed [N];
    logic load;

    // free to load when empty or being drained this cycle
    assign ret.ready = !ret_valid || ret_ready;
    assign load = ret.valid && ret.ready;

    // walk lanes oldest first so a later lane sees an earlier lane's update
    always_comb begin
        map_next = map_q;
        for (int i = 0; i < N; i++) begin
            freed[i] = '0;
            if (load && i < int'(ret.count)) begin
                freed[i] = map_next[ret.entries[i].dest];
                map_next[ret.entries[i].dest] = ret.entries[i].tag;
            end
        end
    end

    // map starts as identity, reg i holds tag i
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                map_q[r] <= tag_t'(r);
            end
        end else begin
            map_q <= map_next;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ret_valid <= 1'b0;
        end else if (ret.ready) begin
            ret_valid <= ret.valid;
        end
    end

    // payload and freed tags move together
    always_ff @(posedge clock) begin
        if (load) begin
            ret_count <= ret.count;
            for (int i = 0; i < N; i++) begin
                ret_dest[i]      <= ret.entries[i].dest;
                ret_tag[i]       <= ret.entries[i].tag;
                ret_freed_tag[i] <= freed[i];
            end
        end
    end

endmodule

// ==== design/rob_top.sv ====
// top level of the in-order back end; dispatch register, ROB and retire register
// plain ports for the outside, interfaces between the internal blocks
`timescale 1ns/1ps

module rob_top #(
    parameter int N     = 2,
    parameter int DEPTH = 16
) (
    input  logic                   clock,
    input  logic                   reset,
    // dispatch group
    input  logic                   in_valid,
    output logic                   in_ready,
    input  rob_pkg::lane_count_t   in_count,
    input  rob_pkg::arch_reg_t     in_dest [N],
    input  rob_pkg::tag_t          in_tag [N],
    // completion broadcast
    input  logic                   done_valid [N],
    input  rob_pkg::tag_t          done_tag [N],
    // retired group
    output logic                   ret_valid,
    input  logic                   ret_ready,
    output rob_pkg::lane_count_t   ret_count,
    output rob_pkg::arch_reg_t     ret_dest [N],
    output rob_pkg::tag_t          ret_tag [N],
    output rob_pkg::tag_t          ret_freed_tag [N]
);

    // free slots after this cycle's release, fed back to dispatch
    logic [$clog2(DEPTH+1)-1:0] free_entries;

    dispatch_if #(.N(N)) u_disp_if ();
    retire_if   #(.N(N)) u_ret_if ();

    dispatch_stage #(.N(N), .DEPTH(DEPTH)) u_dispatch_stage (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_count     (in_count),
        .in_dest      (in_dest),
        .in_tag       (in_tag),
        .in_ready     (in_ready),
        .free_entries (free_entries),
        .disp         (u_disp_if.source)
    );

    reorder_buffer #(.N(N), .DEPTH(DEPTH)) u_reorder_buffer (
        .clock        (clock),
        .reset        (reset),
        .disp         (u_disp_if.sink),
        .done_valid   (done_valid),
        .done_tag     (done_tag),
        .free_entries (free_entries),
        .ret          (u_ret_if.source)
    );

    retire_stage #(.N(N)) u_retire_stage (
        .clock         (clock),
        .reset         (reset),
        .ret           (u_ret_if.sink),
        .ret_valid     (ret_valid),
        .ret_ready     (ret_ready),
        .ret_count     (ret_count),
        .ret_dest      (ret_dest),
        .ret_tag       (ret_tag),
        .ret_freed_tag (ret_freed_tag)
    );

endmodule

// ==== dv/rob_props.sv ====
// concurrent checks on the retire handshake and the ROB occupancy
// attached to rob_top by the bind at the end of this file
`timescale 1ns/1ps

module rob_props #(
    parameter int N     = 2,
    parameter int DEPTH = 16
) (
    input logic                         clock,
    input logic                         reset,
    input logic                         ret_valid,
    input logic                         ret_ready,
    input rob_pkg::lane_count_t         ret_count,
    input rob_pkg::arch_reg_t           ret_dest [N],
    input rob_pkg::tag_t                ret_tag [N],
    input rob_pkg::tag_t                ret_freed_tag [N],
    input logic [$clog2(DEPTH+1)-1:0]   occupancy
);

    import rob_pkg::*;

    localparam int LW = $bits(arch_reg_t) + 2 * $bits(tag_t);

    // all output lanes flattened into one vector
    logic [N*LW-1:0] payload;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            payload[i*LW +: LW] = {ret_dest[i], ret_tag[i], ret_freed_tag[i]};
        end
    end

    // a waiting group stays on the output until taken
    valid_held: assert property (@(posedge clock) disable iff (reset)
        ret_valid && !ret_ready |=> ret_valid)
        else $error("ret_valid dropped while the group was still waiting");

    // payload frozen under back-pressure
    payload_held: assert property (@(posedge clock) disable iff (reset)
        ret_valid && !ret_ready |=> $stable(ret_count) && $stable(payload))
        else $error("retired group changed while ret_ready was low");

    occupancy_bound: assert property (@(posedge clock) disable iff (reset)
        int'(occupancy) <= DEPTH)
        else $error("ROB occupancy went above DEPTH");

endmodule

bind rob_top rob_props #(.N(N), .DEPTH(DEPTH)) u_rob_props (
    .clock         (clock),
    .reset         (reset),
    .ret_valid     (ret_valid),
    .ret_ready     (ret_ready),
    .ret_count     (ret_count),
    .ret_dest      (ret_dest),
    .ret_tag       (ret_tag),
    .ret_freed_tag (ret_freed_tag),
    .occupancy     (u_reorder_buffer.occupancy)
);

// ==== dv/rob_tb.sv ====
// testbench for rob_top; directed and random dispatch, completion and retire traffic
// every output transfer is compared against a model queue and model map
`timescale 1ns/1ps

module rob_tb;

    import rob_pkg::*;

    localparam int N = 2;
    localparam int DEPTH = 16;
    // instructions over the whole run and the base of the watchdog limit
    localparam int NUM_OPS = 400;
    localparam logic [31:0] SEED = 32'h8cedaab4;
    localparam int LIMIT_NS = NUM_OPS * 40 * 8 + 16 * 8;

    logic        clock = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    lane_count_t in_count;
    arch_reg_t   in_dest [N];
    tag_t        in_tag [N];
    logic        done_valid [N];
    tag_t        done_tag [N];
    logic        ret_valid;
    logic        ret_ready;
    lane_count_t ret_count;
    arch_reg_t   ret_dest [N];
    tag_t        ret_tag [N];
    tag_t        ret_freed_tag [N];

    // dispatched but not yet retired in program order
    arch_reg_t exp_dest [$];
    tag_t      exp_tag [$];
    tag_t      model_map [NUM_ARCH_REGS];
    // rename tags held neither by the map nor by an in-flight instruction
    tag_t      tag_pool [$];
    // tags waiting for their broadcast and the first cycle each may complete
    tag_t      pend_tag [$];
    int        pend_due [$];

    int    errors = 0;
    int    cyc = 0;
    int    sent = 0;
    // lanes the DUT has reported as retired
    int    retired = 0;
    string test_name = "reset";

    // traffic knobs
    bit disp_on;
    int grp_fixed;
    int dest_max;
    // 0 none, 1 random order, 2 newest first
    int done_mode;
    // 0 low, 1 high, 2 random with low stretches
    int ready_mode;
    int low_left;

    always #4 clock = ~clock;

    rob_top #(.N(N), .DEPTH(DEPTH)) u_rob_top (.*);

    task automatic check_value(string what, int expected, int actual);
        if (expected != actual) begin
            errors++;
            $display("FAILED %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // pops the oldest instruction and returns the tag its dest mapped to before
    function automatic tag_t retire_model(output arch_reg_t dest, output tag_t tag);
        tag_t freed;
        dest = exp_dest.pop_front();
        tag = exp_tag.pop_front();
        freed = model_map[dest];
        model_map[dest] = tag;
        return freed;
    endfunction

    // one clock per call; books an accepted group and drives the next cycle
    task automatic step();
        int   k;
        int   n;
        int   idx;
        logic hold;
        @(posedge clock);
        cyc++;
        hold = in_valid && !in_ready;
        if (in_valid && in_ready) begin
            for (k = 0; k < int'(in_count); k++) begin
                exp_dest.push_back(in_dest[k]);
                exp_tag.push_back(in_tag[k]);
                pend_tag.push_back(in_tag[k]);
                // written into the ROB one edge later so due at least two edges on
                pend_due.push_back(cyc + 2 + int'($urandom_range(4, 0)));
            end
            sent += int'(in_count);
        end
        // a refused group is held unchanged
        if (!hold) begin
            n = (grp_fixed != 0) ? grp_fixed : int'($urandom_range(N, 1));
            if (disp_on && tag_pool.size() >= n) begin
                in_valid <= 1'b1;
                in_count <= lane_count_t'(n);
                for (k = 0; k < N; k++) begin
                    in_dest[k] <= arch_reg_t'($urandom_range(dest_max, 0));
                    if (k < n) begin
                        in_tag[k] <= tag_pool.pop_front();
                    end
                end
            end else begin
                in_valid <= 1'b0;
            end
        end
        for (k = 0; k < N; k++) begin
            done_valid[k] <= 1'b0;
        end
        if (done_mode == 1) begin
            for (k = 0; k < N; k++) begin
                if (pend_tag.size() > 0 && $urandom_range(3, 0) != 0) begin
                    idx = int'($urandom_range(pend_tag.size() - 1, 0));
                    if (cyc >= pend_due[idx]) begin
                        done_valid[k] <= 1'b1;
                        done_tag[k] <= pend_tag[idx];
                        pend_tag.delete(idx);
                        pend_due.delete(idx);
                    end
                end
            end
        end else if (done_mode == 2 && pend_tag.size() > 0) begin
            if (cyc >= pend_due[pend_due.size() - 1]) begin
                done_valid[0] <= 1'b1;
                done_tag[0] <= pend_tag.pop_back();
                void'(pend_due.pop_back());
            end
        end
        if (ready_mode == 2) begin
            if (low_left > 0) begin
                low_left--;
                ret_ready <= 1'b0;
            end else if ($urandom_range(9, 0) == 0) begin
                low_left = int'($urandom_range(12, 3));
                ret_ready <= 1'b0;
            end else begin
                ret_ready <= ($urandom_range(3, 0) != 0);
            end
        end else begin
            ret_ready <= (ready_mode == 1);
        end
    endtask

    // stop new groups and run until the model queue is empty
    task automatic drain();
        disp_on = 1'b0;
        while (exp_dest.size() != 0 || in_valid) begin
            step();
        end
    endtask

    initial begin : stimulus
        int k;
        int mark;
        void'($urandom(SEED));
        reset <= 1'b1;
        in_valid <= 1'b0;
        in_count <= '0;
        ret_ready <= 1'b0;
        for (k = 0; k < N; k++) begin
            in_dest[k] <= '0;
            in_tag[k] <= '0;
            done_valid[k] <= 1'b0;
            done_tag[k] <= '0;
        end
        // map starts as identity and renames draw from 32..63
        for (k = 0; k < NUM_ARCH_REGS; k++) begin
            model_map[k] = tag_t'(k);
        end
        for (k = 32; k < 64; k++) begin
            tag_pool.push_back(tag_t'(k));
        end
        disp_on = 1'b0;
        grp_fixed = 0;
        // 16 dests at most so the map never holds every rename tag
        dest_max = 15;
        done_mode = 0;
        ready_mode = 0;
        low_left = 0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("in_ready after reset", 1, int'(in_ready));
        check_value("ret_valid after reset", 0, int'(ret_valid));

        // few dests so one group often writes the same dest twice
        // head completes last and blocks the younger completed entries
        test_name = "reverse_completion";
        dest_max = 3;
        ready_mode = 1;
        disp_on = 1'b1;
        while (sent < 8) begin
            step();
        end
        done_mode = 2;
        drain();

        // nothing completes and ret_ready is low so the ROB fills
        test_name = "backpressure";
        dest_max = 15;
        grp_fixed = 2;
        ready_mode = 0;
        done_mode = 0;
        mark = sent;
        disp_on = 1'b1;
        repeat (DEPTH + 8) step();
        @(negedge clock);
        check_value("instructions taken until full", DEPTH, sent - mark);
        check_value("in_ready when full", 0, int'(in_ready));
        // output register loads and must hold while ret_ready stays low
        done_mode = 1;
        repeat (40) step();
        ready_mode = 2;
        grp_fixed = 0;
        drain();

        test_name = "random_run";
        disp_on = 1'b1;
        while (sent < NUM_OPS) begin
            step();
        end
        drain();
        // quiet period so a late or repeated group still shows up
        repeat (2 * DEPTH) step();

        check_value("retired count", sent, retired);
        $display("closing: %0d errors, %0d dispatched, %0d retired", errors, sent, retired);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // sampled at the falling edge so a transfer seen here completes on the next rising edge
    initial begin : compare
        int        i;
        arch_reg_t d;
        tag_t      t;
        tag_t      f;
        forever begin
            @(negedge clock);
            if (!reset && ret_valid && ret_ready) begin
                check_value("ret_count in 1..N", 1,
                            int'(int'(ret_count) >= 1 && int'(ret_count) <= N));
                for (i = 0; i < int'(ret_count) && i < N; i++) begin
                    retired++;
                    if (exp_dest.size() == 0) begin
                        errors++;
                        $display("%s: more instructions retired than were dispatched",
                                 test_name);
                    end else begin
                        f = retire_model(d, t);
                        check_value($sformatf("lane %0d dest", i), int'(d), int'(ret_dest[i]));
                        check_value($sformatf("lane %0d tag", i), int'(t), int'(ret_tag[i]));
                        check_value($sformatf("lane %0d freed tag", i), int'(f),
                                    int'(ret_freed_tag[i]));
                        // only rename tags go back to the pool
                        if (f >= tag_t'(32)) begin
                            tag_pool.push_back(f);
                        end
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(LIMIT_NS);
        $display("timeout: the run did not finish within %0d ns", LIMIT_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== rob_top.f ====
design/rob_pkg.sv
design/dispatch_if.sv
design/retire_if.sv
design/dispatch_stage.sv
design/reorder_buffer.sv
design/retire_stage.sv
design/rob_top.sv
dv/rob_props.sv
dv/rob_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rob_tb -f rob_top.f -Mdir obj_dir -o rob_sim
./obj_dir/rob_sim 2>&1 | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
